/* noc_pkg.sv */
/*
 * Interconnect package
 * Packet widths, response status codes and the shared packet word layout
 */
package noc_pkg;

    // ------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int SEL_W    = 4;
    localparam int SRC_ID_W = 2;
    localparam int STATUS_W = 2;
    localparam int PKT_W    = 72;

    // Spare bits left over in each view of the word
    localparam int CMD_RSVD_W = PKT_W - 1 - SRC_ID_W - SEL_W - ADDR_W - DATA_W;
    localparam int RSP_RSVD_W = PKT_W - 1 - SRC_ID_W - STATUS_W - DATA_W;

    // ------------------------------------------------------------
    // Response status codes
    // ------------------------------------------------------------
    localparam logic [STATUS_W-1:0] STATUS_OKAY  = 2'd0;
    localparam logic [STATUS_W-1:0] STATUS_ERROR = 2'd2;

    // ------------------------------------------------------------
    // Packet word, one 72-bit word read two ways
    // ------------------------------------------------------------
    typedef union packed {
        // Command, master to slave
        struct packed {
            logic                  write;
            logic [SRC_ID_W-1:0]   src_id;
            logic [SEL_W-1:0]      sel;
            logic [ADDR_W-1:0]     addr;
            logic [DATA_W-1:0]     data;
            logic [CMD_RSVD_W-1:0] rsvd;
        } cmd;
        // Response, slave back to master
        struct packed {
            logic                  write;
            logic [SRC_ID_W-1:0]   src_id;
            logic [STATUS_W-1:0]   status;
            logic [RSP_RSVD_W-1:0] rsvd;
            logic [DATA_W-1:0]     data;
        } rsp;
    } pkt_word_u;

endpackage

/* link_fifo.sv */
/*
 * Packet link buffer
 * Valid/ready ring buffer for packet words, one cycle of latency
 */
module link_fifo #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic               clk,
    input  logic               reset,
    // Write side
    input  logic               in_valid,
    input  noc_pkg::pkt_word_u in_data,
    output logic               in_ready,
    // Read side
    output logic               out_valid,
    output noc_pkg::pkt_word_u out_data,
    input  logic               out_ready
);
    import noc_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    pkt_word_u      mem [FIFO_DEPTH];
    // Extra top bit tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           full;
    logic           empty;
    logic           wr_en;
    logic           rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[PTR_W-1:0]];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // ------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr[PTR_W-1:0]] <= in_data;
    end

    // Word refused while full is still offered on the next edge, not lost
    ap_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_data)));

endmodule

/* master_agent.sv */
/*
 * Master agent
 * Turns Wishbone classic host cycles into command packet words and
 * ends each host cycle with ack or err from the returning response word
 */
module master_agent #(
    parameter logic [noc_pkg::SRC_ID_W-1:0] AGENT_ID = 2'd1
) (
    input  logic                       clk,
    input  logic                       reset,
    // Host side
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [noc_pkg::ADDR_W-1:0] adr,
    input  logic [noc_pkg::DATA_W-1:0] dat_w,
    input  logic [noc_pkg::SEL_W-1:0]  sel,
    output logic [noc_pkg::DATA_W-1:0] dat_r,
    output logic                       ack,
    output logic                       err,
    // Command link out
    output logic                       cmd_valid,
    output noc_pkg::pkt_word_u         cmd_data,
    input  logic                       cmd_ready,
    // Response link in
    input  logic                       rsp_valid,
    input  noc_pkg::pkt_word_u         rsp_data,
    output logic                       rsp_ready
);
    import noc_pkg::*;

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic state;
    logic pend_we;
    logic cmd_fire;
    logic rsp_fire;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------
    // One command per host cycle, only while idle
    assign cmd_valid = (state == ST_IDLE) && cyc && stb;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign rsp_ready = (state == ST_WAIT);
    assign rsp_fire  = rsp_valid && rsp_ready;

    // Command word straight from the held host signals
    always_comb begin
        cmd_data            = '0;
        cmd_data.cmd.write  = we;
        cmd_data.cmd.src_id = AGENT_ID;
        cmd_data.cmd.sel    = sel;
        // Word aligned address
        cmd_data.cmd.addr   = {adr[ADDR_W-1:2], 2'b00};
        cmd_data.cmd.data   = dat_w;
    end

    // Host cycle ends in the response transfer cycle
    assign dat_r = rsp_data.rsp.data;
    assign ack   = rsp_fire && (rsp_data.rsp.status == STATUS_OKAY);
    // Any non-okay status ends as err
    assign err   = rsp_fire && (rsp_data.rsp.status != STATUS_OKAY);

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (state == ST_IDLE) begin
            if (cmd_fire)
                state <= ST_WAIT;
        end else if (rsp_fire) begin
            state <= ST_IDLE;
        end
    end

    // Direction of the outstanding transfer
    always_ff @(posedge clk) begin
        if (cmd_fire)
            pend_we <= we;
    end

    // Response must come back to this agent
    ap_rsp_id: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> (rsp_data.rsp.src_id == AGENT_ID));

    // Echoed write flag matches the command sent
    ap_rsp_we: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> (rsp_data.rsp.write == pend_we));

endmodule

/* slave_agent.sv */
/*
 * Slave agent
 * Runs each command packet as a Wishbone classic cycle on the memory
 * and returns one response packet word
 */
module slave_agent (
    input  logic                       clk,
    input  logic                       reset,
    // Command link in
    input  logic                       cmd_valid,
    input  noc_pkg::pkt_word_u         cmd_data,
    output logic                       cmd_ready,
    // Response link out
    output logic                       rsp_valid,
    output noc_pkg::pkt_word_u         rsp_data,
    input  logic                       rsp_ready,
    // Memory side
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [noc_pkg::ADDR_W-1:0] wb_adr,
    output logic [noc_pkg::DATA_W-1:0] wb_dat_w,
    output logic [noc_pkg::SEL_W-1:0]  wb_sel,
    input  logic [noc_pkg::DATA_W-1:0] wb_dat_r,
    input  logic                       wb_ack,
    input  logic                       wb_err
);
    import noc_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUS  = 2'd1;
    localparam logic [1:0] ST_RESP = 2'd2;

    logic [1:0]          state;
    logic                cmd_fire;
    logic                bus_done;
    logic                rsp_fire;
    // Captured command
    logic                req_we;
    logic [SRC_ID_W-1:0] req_src;
    logic [ADDR_W-1:0]   req_adr;
    logic [DATA_W-1:0]   req_dat;
    logic [SEL_W-1:0]    req_sel;
    pkt_word_u           rsp_q;

    // Commands only accepted when idle, so a stalled response blocks them
    assign cmd_ready = (state == ST_IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign bus_done  = (state == ST_BUS) && (wb_ack || wb_err);
    assign rsp_valid = (state == ST_RESP);
    assign rsp_fire  = rsp_valid && rsp_ready;
    assign rsp_data  = rsp_q;

    // Memory cycle held for the whole bus state
    assign wb_cyc   = (state == ST_BUS);
    assign wb_stb   = (state == ST_BUS);
    assign wb_we    = req_we;
    assign wb_adr   = req_adr;
    assign wb_dat_w = req_dat;
    assign wb_sel   = req_sel;

    // ------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (cmd_fire) state <= ST_BUS;
                ST_BUS:  if (bus_done) state <= ST_RESP;
                ST_RESP: if (rsp_fire) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command capture and response build
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            req_we  <= cmd_data.cmd.write;
            req_src <= cmd_data.cmd.src_id;
            req_adr <= cmd_data.cmd.addr;
            req_dat <= cmd_data.cmd.data;
            req_sel <= cmd_data.cmd.sel;
        end
        if (bus_done) begin
            rsp_q            <= '0;
            rsp_q.rsp.write  <= req_we;
            rsp_q.rsp.src_id <= req_src;
            rsp_q.rsp.status <= wb_err ? STATUS_ERROR : STATUS_OKAY;
            // No read data on writes
            rsp_q.rsp.data   <= req_we ? '0 : wb_dat_r;
        end
    end

    // Memory never ends a cycle both ways at once
    ap_ack_err: assert property (@(posedge clk) disable iff (reset)
        !(wb_ack && wb_err));

endmodule

/* wb_memory.sv */
/*
 * Wishbone classic word memory
 * Byte lane writes, one wait state, err for a word outside its range
 */
module wb_memory #(
    parameter int MEM_WORDS = 64
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [noc_pkg::ADDR_W-1:0] adr,
    input  logic [noc_pkg::DATA_W-1:0] dat_w,
    input  logic [noc_pkg::SEL_W-1:0]  sel,
    output logic [noc_pkg::DATA_W-1:0] dat_r,
    output logic                       ack,
    output logic                       err
);
    import noc_pkg::*;

    localparam int                IDX_W     = $clog2(MEM_WORDS);
    localparam logic [ADDR_W-1:0] MEM_LIMIT = ADDR_W'(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              wait_q;
    logic              start;
    logic              in_range;
    logic [IDX_W-1:0]  idx;

    // Word index from the byte address
    assign in_range = (adr >> 2) < MEM_LIMIT;
    assign idx      = adr[IDX_W+1:2];
    // New request, not the tail of one just ended
    assign start    = cyc && stb && !wait_q && !ack && !err;

    // ------------------------------------------------------------
    // Response flags, one wait state after stb is seen
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_q <= 1'b0;
            ack    <= 1'b0;
            err    <= 1'b0;
        end else begin
            wait_q <= start;
            ack    <= wait_q && in_range;
            err    <= wait_q && !in_range;
        end
    end

    // Array access on the ack edge
    always_ff @(posedge clk) begin
        if (wait_q) begin
            dat_r <= in_range ? mem[idx] : '0;
            if (we && in_range) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (sel[i])
                        mem[idx][8*i +: 8] <= dat_w[8*i +: 8];
                end
            end
        end
    end

endmodule

/* noc_top.sv */
/*
 * Interconnect top level
 * Master agent, command and response links, slave agent and memory
 */
module noc_top #(
    parameter logic [noc_pkg::SRC_ID_W-1:0] AGENT_ID   = 2'd1,
    parameter int                           FIFO_DEPTH = 2,
    parameter int                           MEM_WORDS  = 64
) (
    input  logic                       clk,
    input  logic                       reset,
    // Host Wishbone classic
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [noc_pkg::ADDR_W-1:0] adr,
    input  logic [noc_pkg::DATA_W-1:0] dat_w,
    input  logic [noc_pkg::SEL_W-1:0]  sel,
    output logic [noc_pkg::DATA_W-1:0] dat_r,
    output logic                       ack,
    output logic                       err
);
    import noc_pkg::*;

    // Command path, master side then slave side
    logic              cmd_m_valid;
    logic              cmd_m_ready;
    pkt_word_u         cmd_m_data;
    logic              cmd_s_valid;
    logic              cmd_s_ready;
    pkt_word_u         cmd_s_data;
    // Response path, slave side then master side
    logic              rsp_s_valid;
    logic              rsp_s_ready;
    pkt_word_u         rsp_s_data;
    logic              rsp_m_valid;
    logic              rsp_m_ready;
    pkt_word_u         rsp_m_data;
    // Memory bus
    logic              mem_cyc;
    logic              mem_stb;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_adr;
    logic [DATA_W-1:0] mem_dat_w;
    logic [SEL_W-1:0]  mem_sel;
    logic [DATA_W-1:0] mem_dat_r;
    logic              mem_ack;
    logic              mem_err;

    master_agent #(.AGENT_ID(AGENT_ID)) master (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
        .dat_r(dat_r), .ack(ack), .err(err),
        .cmd_valid(cmd_m_valid), .cmd_data(cmd_m_data), .cmd_ready(cmd_m_ready),
        .rsp_valid(rsp_m_valid), .rsp_data(rsp_m_data), .rsp_ready(rsp_m_ready)
    );

    link_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_link (
        .clk(clk), .reset(reset),
        .in_valid(cmd_m_valid), .in_data(cmd_m_data), .in_ready(cmd_m_ready),
        .out_valid(cmd_s_valid), .out_data(cmd_s_data), .out_ready(cmd_s_ready)
    );

    link_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rsp_link (
        .clk(clk), .reset(reset),
        .in_valid(rsp_s_valid), .in_data(rsp_s_data), .in_ready(rsp_s_ready),
        .out_valid(rsp_m_valid), .out_data(rsp_m_data), .out_ready(rsp_m_ready)
    );

    slave_agent slave (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_s_valid), .cmd_data(cmd_s_data), .cmd_ready(cmd_s_ready),
        .rsp_valid(rsp_s_valid), .rsp_data(rsp_s_data), .rsp_ready(rsp_s_ready),
        .wb_cyc(mem_cyc), .wb_stb(mem_stb), .wb_we(mem_we), .wb_adr(mem_adr),
        .wb_dat_w(mem_dat_w), .wb_sel(mem_sel),
        .wb_dat_r(mem_dat_r), .wb_ack(mem_ack), .wb_err(mem_err)
    );

    wb_memory #(.MEM_WORDS(MEM_WORDS)) memory (
        .clk(clk), .reset(reset),
        .cyc(mem_cyc), .stb(mem_stb), .we(mem_we), .adr(mem_adr),
        .dat_w(mem_dat_w), .sel(mem_sel),
        .dat_r(mem_dat_r), .ack(mem_ack), .err(mem_err)
    );

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 20 ns clock, reset high for the first 4 rising edges
 */
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* noc_tb.sv */
/*
 * Interconnect testbench
 * Host Wishbone transfers from a stimulus table and a random phase,
 * checked against a byte lane reference model of the memory
 */
module noc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import noc_pkg::*;

    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 50;
    localparam int N_STIM    = 14;

    typedef struct packed {
        logic                we;
        logic [ADDR_W-1:0]   adr;
        logic [DATA_W-1:0]   data;
        logic [SEL_W-1:0]    sel;
        logic [DATA_W-1:0]   exp_data;
        logic [STATUS_W-1:0] exp_status;
    } stim_t;

    logic              clk;
    logic              reset;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [SEL_W-1:0]  sel;
    logic [DATA_W-1:0] dat_r;
    logic              ack;
    logic              err;

    stim_t             stim [N_STIM];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    int                data_errors;
    int                status_errors;
    int                timeouts;
    int                seed;

    tb_clock_gen clock_gen (.clk(clk), .reset(reset));

    noc_top uut (
        .clk(clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
        .dat_r(dat_r), .ack(ack), .err(err)
    );

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s read data %h, expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_status(input logic [STATUS_W-1:0] got,
                                input logic [STATUS_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s status %0d, expected %0d", $time, what, got, exp);
            status_errors++;
        end
    endtask

    // Reference memory, byte lanes under sel, nothing outside the range
    task automatic update_model(input logic wr, input logic [ADDR_W-1:0] a,
                                input logic [DATA_W-1:0] d, input logic [SEL_W-1:0] s);
        int word;
        word = int'(a >> 2);
        if (wr && (a >> 2) < MEM_WORDS) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (s[i])
                    ref_mem[word][8*i +: 8] = d[8*i +: 8];
            end
        end
    endtask

    // ------------------------------------------------------------
    // One host transfer, held until ack or err
    // ------------------------------------------------------------
    task automatic apply_transfer(input logic wr, input logic [ADDR_W-1:0] a,
                                  input logic [DATA_W-1:0] d, input logic [SEL_W-1:0] s,
                                  input logic [DATA_W-1:0] exp_d,
                                  input logic [STATUS_W-1:0] exp_s, input string what);
        logic seen;
        int   cycles;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        sel   = s;
        seen   = 1'b0;
        cycles = 0;
        // Sampled mid cycle, where ack and err have settled
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (ack || err)
                seen = 1'b1;
        end
        if (seen) begin
            check_data(dat_r, exp_d, what);
            check_status(ack ? STATUS_OKAY : STATUS_ERROR, exp_s, what);
        end else begin
            $display("Timeout: no ack or err within %0d cycles for %s at address %h",
                     TIMEOUT, what, a);
            timeouts++;
        end
        update_model(wr, a, d, s);
        // Rising edge in between ends the cycle
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // we, address, data, sel, expected data, expected status
    task automatic load_table;
        stim[0]  = '{1'b1, 32'h0000_0010, 32'h1234_5678, 4'hf, 32'h0, STATUS_OKAY};
        stim[1]  = '{1'b0, 32'h0000_0010, 32'h0, 4'hf, 32'h1234_5678, STATUS_OKAY};
        // Partial writes merge with the old bytes
        stim[2]  = '{1'b1, 32'h0000_0014, 32'ha5a5_a5a5, 4'hf, 32'h0, STATUS_OKAY};
        stim[3]  = '{1'b1, 32'h0000_0014, 32'h003c_0000, 4'b0100, 32'h0, STATUS_OKAY};
        stim[4]  = '{1'b1, 32'h0000_0014, 32'h0000_005a, 4'b0001, 32'h0, STATUS_OKAY};
        stim[5]  = '{1'b0, 32'h0000_0014, 32'h0, 4'hf, 32'ha53c_a55a, STATUS_OKAY};
        // Low address bits ignored
        stim[6]  = '{1'b1, 32'h0000_0023, 32'hcafe_f00d, 4'hf, 32'h0, STATUS_OKAY};
        stim[7]  = '{1'b0, 32'h0000_0020, 32'h0, 4'hf, 32'hcafe_f00d, STATUS_OKAY};
        stim[8]  = '{1'b0, 32'h0000_0022, 32'h0, 4'hf, 32'hcafe_f00d, STATUS_OKAY};
        // Out of range, 0x100 would alias word 0
        stim[9]  = '{1'b1, 32'h0000_0000, 32'h1111_1111, 4'hf, 32'h0, STATUS_OKAY};
        stim[10] = '{1'b1, 32'h0000_0100, 32'hdead_beef, 4'hf, 32'h0, STATUS_ERROR};
        stim[11] = '{1'b0, 32'h0000_0104, 32'h0, 4'hf, 32'h0, STATUS_ERROR};
        stim[12] = '{1'b1, 32'hffff_fff0, 32'h0, 4'hf, 32'h0, STATUS_ERROR};
        stim[13] = '{1'b0, 32'h0000_0000, 32'h0, 4'hf, 32'h1111_1111, STATUS_OKAY};
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [31:0]       r;
        int                word;
        int                cycles;
        cyc           = 1'b0;
        stb           = 1'b0;
        we            = 1'b0;
        adr           = '0;
        dat_w         = '0;
        sel           = '0;
        data_errors   = 0;
        status_errors = 0;
        timeouts      = 0;
        seed          = 32'hddfb;
        load_table();

        cycles = 0;
        while (reset !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was still high after %0d cycles", TIMEOUT);
            timeouts++;
        end

        // Quiet bus after reset
        repeat (6) begin
            @(negedge clk);
            check_status({ack, err}, 2'b00, "idle ack/err");
        end

        // Known contents, pattern from the full byte address
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = ADDR_W'(i) << 2;
            apply_transfer(1'b1, a, {a[15:0], ~a[15:0]}, 4'hf, '0, STATUS_OKAY, "fill");
        end

        for (int i = 0; i < N_STIM; i++)
            apply_transfer(stim[i].we, stim[i].adr, stim[i].data, stim[i].sel,
                           stim[i].exp_data, stim[i].exp_status,
                           $sformatf("table entry %0d", i));

        // Random phase inside the range
        for (int i = 0; i < 40; i++) begin
            r    = $random(seed);
            d    = $random(seed);
            word = int'(r[15:0]) % MEM_WORDS;
            a    = ADDR_W'(word) << 2;
            a[1:0] = r[17:16];
            apply_transfer(r[20], a, d, r[27:24], r[20] ? '0 : ref_mem[word],
                           STATUS_OKAY, $sformatf("random %0d", i));
        end

        $display("Errors: data %0d, status %0d, timeouts %0d",
                 data_errors, status_errors, timeouts);
        if (data_errors + status_errors + timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* build.f */
noc_pkg.sv
link_fifo.sv
master_agent.sv
slave_agent.sv
wb_memory.sv
noc_top.sv
tb_clock_gen.sv
noc_tb.sv

/* Makefile */
# Verilator build and run for the packet interconnect testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = noc_tb
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
